/* cache_pkg.sv */
// shared widths, bus structs and cache FSM states, referenced by package::name from every file
`default_nettype none

package cache_pkg;

    localparam int ADDR_W = 32;           // byte address
    localparam int DATA_W = 32;           // one bus word
    localparam int BE_W   = DATA_W / 8;   // one enable per byte lane

    // generic request, used at the processor port and the cache memory port
    typedef struct packed {
        logic              ren;       // read request
        logic              wen;       // write request
        logic [ADDR_W-1:0] addr;      // byte address, word aligned
        logic [DATA_W-1:0] wdata;     // store data
        logic [BE_W-1:0]   byte_en;   // lanes written on a store
    } gen_req_t;

    typedef struct packed {
        logic              busy;      // low for exactly the completion cycle
        logic [DATA_W-1:0] rdata;     // valid while busy is low on a read
    } gen_rsp_t;

    // one per-CPU slot at the bus controller
    typedef struct packed {
        logic              dren;      // set for reads and writes alike
        logic              dwen;      // write
        logic [ADDR_W-1:0] daddr;
        logic [DATA_W-1:0] dstore;
        logic [BE_W-1:0]   dbyte_en;
    } bus_req_t;

    typedef struct packed {
        logic              dwait;     // low in the completion cycle
        logic [DATA_W-1:0] dload;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        IDLE,          // lookup, hit service
        WRITEBACK,     // dirty victim out, word by word
        FILL,          // line in from memory
        BYPASS,        // uncached access passed through
        FLUSH_SCAN,    // walk sets for dirty lines
        FLUSH_WB,      // write back one line during flush
        CLEAR_SCAN     // invalidate every set
    } cache_state_e;

endpackage

`default_nettype wire

/* l1_cache.sv */
// direct-mapped write-back L1 data cache with uncached bypass, flush and clear; used per CPU
`timescale 1ns/100ps
`default_nettype none

module l1_cache #(
    parameter int CACHE_SIZE = 256,   // bytes, power of two
    parameter int BLOCK_SIZE = 2,     // words per line, power of two, 2 to 8
    parameter logic [cache_pkg::ADDR_W-1:0] NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic                clear,
    input  logic                flush,
    output logic                clear_done,
    output logic                flush_done,
    input  cache_pkg::gen_req_t proc_req,
    output cache_pkg::gen_rsp_t proc_rsp,
    output cache_pkg::gen_req_t mem_req,
    input  cache_pkg::gen_rsp_t mem_rsp
);
    localparam int N_SETS = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int OFF_W  = $clog2(BLOCK_SIZE);
    localparam int IDX_W  = $clog2(N_SETS);
    localparam int TAG_W  = cache_pkg::ADDR_W - IDX_W - OFF_W - 2;

    cache_pkg::cache_state_e      state;
    logic [TAG_W-1:0]             tag_mem  [N_SETS];
    logic [cache_pkg::DATA_W-1:0] data_mem [N_SETS][BLOCK_SIZE];
    logic [N_SETS-1:0]            valid;
    logic [N_SETS-1:0]            dirty;
    logic [IDX_W-1:0]             scan_idx;     // flush/clear walk pointer
    logic [OFF_W-1:0]             wcnt;         // word within the line
    logic                         hit_q;        // hit answered this cycle
    logic [cache_pkg::DATA_W-1:0] rdata_q;      // hit read data
    logic                         flush_pend;   // flush seen, not yet started
    logic                         clear_pend;

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] wb_idx;
    logic [OFF_W-1:0] req_off;
    logic             req_act;
    logic             cacheable;
    logic             hit;
    logic             last_word;
    logic             last_set;

    assign req_tag   = proc_req.addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign req_idx   = proc_req.addr[2+OFF_W +: IDX_W];
    assign req_off   = proc_req.addr[2 +: OFF_W];
    assign req_act   = proc_req.ren | proc_req.wen;
    assign cacheable = proc_req.addr < NONCACHE_START_ADDR;
    assign hit       = valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign last_word = (wcnt == OFF_W'(BLOCK_SIZE - 1));
    assign last_set  = (scan_idx == IDX_W'(N_SETS - 1));
    assign wb_idx    = (state == cache_pkg::FLUSH_WB) ? scan_idx : req_idx;  // victim set

    always_comb begin
        mem_req = '0;
        case (state)
            cache_pkg::WRITEBACK, cache_pkg::FLUSH_WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = {tag_mem[wb_idx], wb_idx, wcnt, 2'b00};  // victim address
                mem_req.wdata   = data_mem[wb_idx][wcnt];
                mem_req.byte_en = '1;                                     // full word out
            end
            cache_pkg::FILL: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_tag, req_idx, wcnt, 2'b00};
            end
            cache_pkg::BYPASS: mem_req = proc_req;   // uncached, straight through
            default: ;
        endcase
    end

    always_comb begin
        proc_rsp.busy  = 1'b1;
        proc_rsp.rdata = rdata_q;
        if (state == cache_pkg::BYPASS) begin
            proc_rsp.busy  = mem_rsp.busy;   // memory completion is ours
            proc_rsp.rdata = mem_rsp.rdata;
        end else if (hit_q) begin
            proc_rsp.busy = 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= cache_pkg::IDLE;
            valid      <= '0;
            dirty      <= '0;
            scan_idx   <= '0;
            wcnt       <= '0;
            hit_q      <= 1'b0;
            flush_pend <= 1'b0;
            clear_pend <= 1'b0;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;   // single-cycle pulses
            clear_done <= 1'b0;
            if (flush) flush_pend <= 1'b1;
            if (clear) clear_pend <= 1'b1;
            case (state)
                cache_pkg::IDLE: begin
                    hit_q <= 1'b0;
                    if (hit_q) begin
                        // completion cycle, the finished request is still on the port
                    end else if (flush_pend) begin
                        flush_pend <= 1'b0;
                        scan_idx   <= '0;
                        state      <= cache_pkg::FLUSH_SCAN;
                    end else if (clear_pend) begin
                        clear_pend <= 1'b0;
                        scan_idx   <= '0;
                        state      <= cache_pkg::CLEAR_SCAN;
                    end else if (req_act && !cacheable) begin
                        state <= cache_pkg::BYPASS;
                    end else if (req_act && hit) begin
                        hit_q   <= 1'b1;
                        rdata_q <= data_mem[req_idx][req_off];
                        if (proc_req.wen) begin
                            dirty[req_idx] <= 1'b1;
                            for (int b = 0; b < cache_pkg::BE_W; b++) begin
                                if (proc_req.byte_en[b])   // merge enabled lanes
                                    data_mem[req_idx][req_off][8*b +: 8] <= proc_req.wdata[8*b +: 8];
                            end
                        end
                    end else if (req_act) begin
                        wcnt  <= '0;
                        state <= (valid[req_idx] && dirty[req_idx]) ? cache_pkg::WRITEBACK
                                                                    : cache_pkg::FILL;
                    end
                end
                cache_pkg::WRITEBACK: if (!mem_rsp.busy) begin
                    wcnt <= wcnt + 1'b1;   // wraps to 0 for the fill
                    if (last_word) begin
                        dirty[req_idx] <= 1'b0;
                        state          <= cache_pkg::FILL;
                    end
                end
                cache_pkg::FILL: if (!mem_rsp.busy) begin
                    data_mem[req_idx][wcnt] <= mem_rsp.rdata;
                    wcnt                    <= wcnt + 1'b1;
                    if (last_word) begin
                        tag_mem[req_idx] <= req_tag;
                        valid[req_idx]   <= 1'b1;
                        state            <= cache_pkg::IDLE;   // request now hits
                    end
                end
                cache_pkg::BYPASS: if (!mem_rsp.busy) state <= cache_pkg::IDLE;
                cache_pkg::FLUSH_SCAN: begin
                    if (valid[scan_idx] && dirty[scan_idx]) begin
                        wcnt  <= '0;
                        state <= cache_pkg::FLUSH_WB;
                    end else begin
                        valid[scan_idx] <= 1'b0;
                        scan_idx        <= scan_idx + 1'b1;
                        if (last_set) begin
                            flush_done <= 1'b1;
                            state      <= cache_pkg::IDLE;
                        end
                    end
                end
                cache_pkg::FLUSH_WB: if (!mem_rsp.busy) begin
                    wcnt <= wcnt + 1'b1;
                    if (last_word) begin
                        dirty[scan_idx] <= 1'b0;              // rescan invalidates it
                        state           <= cache_pkg::FLUSH_SCAN;
                    end
                end
                cache_pkg::CLEAR_SCAN: begin
                    valid[scan_idx] <= 1'b0;   // dropped, no writeback
                    dirty[scan_idx] <= 1'b0;
                    scan_idx        <= scan_idx + 1'b1;
                    if (last_set) begin
                        clear_done <= 1'b1;
                        state      <= cache_pkg::IDLE;
                    end
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* l1_cache_noncoherent.sv */
// noncoherent wrapper: one l1_cache whose memory port drives bus slot CPUID of the controller
`timescale 1ns/100ps
`default_nettype none

module l1_cache_noncoherent #(
    parameter int CPUID      = 0,     // slot index at the bus controller
    parameter int CACHE_SIZE = 256,
    parameter int BLOCK_SIZE = 2,
    parameter logic [cache_pkg::ADDR_W-1:0] NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic                clear,
    input  logic                flush,
    output logic                clear_done,
    output logic                flush_done,
    input  cache_pkg::gen_req_t proc_req,
    output cache_pkg::gen_rsp_t proc_rsp,
    output cache_pkg::bus_req_t bus_req,
    input  cache_pkg::bus_rsp_t bus_rsp
);
    cache_pkg::gen_req_t mem_req;
    cache_pkg::gen_rsp_t mem_rsp;

    if (CPUID < 0) begin : g_bad_cpuid
        $error("l1_cache_noncoherent: CPUID must be a valid slot index");
    end

    l1_cache #(
        .CACHE_SIZE         (CACHE_SIZE),
        .BLOCK_SIZE         (BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) cache (
        .CLK       (CLK),
        .rst       (rst),
        .clear     (clear),
        .flush     (flush),
        .clear_done(clear_done),
        .flush_done(flush_done),
        .proc_req  (proc_req),
        .proc_rsp  (proc_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    // no snoop side, the slot carries plain word traffic
    always_comb begin
        bus_req.dren     = mem_req.ren | mem_req.wen;   // any access asks for the bus
        bus_req.dwen     = mem_req.wen;
        bus_req.daddr    = mem_req.addr;
        bus_req.dstore   = mem_req.wdata;
        bus_req.dbyte_en = mem_req.byte_en;
        mem_rsp.busy     = bus_rsp.dwait;
        mem_rsp.rdata    = bus_rsp.dload;
    end

endmodule

`default_nettype wire

/* bus_ctrl.sv */
// round-robin bus controller, forwards one word transaction at a time from a CPU slot to memory
`timescale 1ns/100ps
`default_nettype none

module bus_ctrl #(
    parameter int NUM_CPUS = 2
) (
    input  logic                CLK,
    input  logic                rst,
    input  cache_pkg::bus_req_t slot_req [NUM_CPUS],
    output cache_pkg::bus_rsp_t slot_rsp [NUM_CPUS],
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp
);
    localparam int SEL_W = (NUM_CPUS > 1) ? $clog2(NUM_CPUS) : 1;

    logic             gnt_valid;   // a word transaction is in flight
    logic [SEL_W-1:0] gnt_idx;     // owner of the bus
    logic [SEL_W-1:0] rr_ptr;      // first slot looked at next time
    logic             pick_valid;
    logic [SEL_W-1:0] pick_idx;
    logic [SEL_W-1:0] cand;
    logic             done;

    assign done = gnt_valid && !mem_rsp.dwait;   // completion cycle of the granted word

    // first requesting slot at or after the pointer
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        cand       = '0;
        for (int i = 0; i < NUM_CPUS; i++) begin
            cand = SEL_W'((int'(rr_ptr) + i) % NUM_CPUS);
            if (!pick_valid && (slot_req[cand].dren || slot_req[cand].dwen)) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= '0;
            rr_ptr    <= '0;
        end else if (!gnt_valid) begin
            gnt_valid <= pick_valid;   // choose only when idle
            gnt_idx   <= pick_idx;
        end else if (done) begin
            gnt_valid <= 1'b0;         // released in the completion cycle
            rr_ptr    <= (gnt_idx == SEL_W'(NUM_CPUS - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

    assign mem_req = gnt_valid ? slot_req[gnt_idx] : '0;

    always_comb begin
        for (int i = 0; i < NUM_CPUS; i++) begin
            slot_rsp[i].dload = mem_rsp.dload;
            slot_rsp[i].dwait = 1'b1;                  // others wait
            if (gnt_valid && (gnt_idx == SEL_W'(i)))
                slot_rsp[i].dwait = mem_rsp.dwait;
        end
    end

endmodule

`default_nettype wire

/* main_memory.sv */
// word-addressed main memory model, answers each bus transaction after a fixed latency
`timescale 1ns/100ps
`default_nettype none

module main_memory #(
    parameter int MEM_LATENCY = 3,      // wait cycles before completion
    parameter int MEM_WORDS   = 1024    // addresses wrap modulo this
) (
    input  logic                CLK,
    input  logic                rst,
    input  cache_pkg::bus_req_t mem_req,
    output cache_pkg::bus_rsp_t mem_rsp
);
    localparam int AW  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 2);

    logic [cache_pkg::DATA_W-1:0] mem [MEM_WORDS];
    logic [CNT_W-1:0]             cnt;        // cycles seen for the current request
    logic [AW-1:0]                widx;
    logic                         active;
    logic                         complete;

    assign widx     = AW'((mem_req.daddr >> 2) % MEM_WORDS);   // word address, wrapped
    assign active   = mem_req.dren | mem_req.dwen;
    assign complete = active && (cnt == CNT_W'(MEM_LATENCY));

    assign mem_rsp.dwait = !complete;
    assign mem_rsp.dload = mem[widx];   // sampled in the completion cycle

    always_ff @(posedge CLK) begin
        if (rst) begin
            cnt <= '0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (complete) begin
            cnt <= '0;                  // ready for the next word
            if (mem_req.dwen) begin
                for (int b = 0; b < cache_pkg::BE_W; b++) begin
                    if (mem_req.dbyte_en[b])
                        mem[widx][8*b +: 8] <= mem_req.dstore[8*b +: 8];
                end
            end
        end else if (active) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cache_subsystem.sv */
// top level: per-CPU noncoherent L1 caches sharing one bus controller and main memory
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem #(
    parameter int CACHE_SIZE  = 256,
    parameter int BLOCK_SIZE  = 2,
    parameter logic [cache_pkg::ADDR_W-1:0] NONCACHE_START_ADDR = 32'h8000_0000,
    parameter int NUM_CPUS    = 2,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 1024
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic [NUM_CPUS-1:0] clear,
    input  logic [NUM_CPUS-1:0] flush,
    output logic [NUM_CPUS-1:0] clear_done,
    output logic [NUM_CPUS-1:0] flush_done,
    input  cache_pkg::gen_req_t proc_req [NUM_CPUS],
    output cache_pkg::gen_rsp_t proc_rsp [NUM_CPUS]
);
    cache_pkg::bus_req_t slot_req [NUM_CPUS];   // one slot per CPU
    cache_pkg::bus_rsp_t slot_rsp [NUM_CPUS];
    cache_pkg::bus_req_t mem_req;
    cache_pkg::bus_rsp_t mem_rsp;

    for (genvar c = 0; c < NUM_CPUS; c++) begin : g_cpu
        l1_cache_noncoherent #(
            .CPUID(c), .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE),
            .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
        ) dcache (
            .CLK(CLK), .rst(rst), .clear(clear[c]), .flush(flush[c]),
            .clear_done(clear_done[c]), .flush_done(flush_done[c]),
            .proc_req(proc_req[c]), .proc_rsp(proc_rsp[c]),
            .bus_req(slot_req[c]), .bus_rsp(slot_rsp[c])
        );
    end

    bus_ctrl #(.NUM_CPUS(NUM_CPUS)) bus (
        .CLK(CLK), .rst(rst), .slot_req(slot_req), .slot_rsp(slot_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    main_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) mem (
        .CLK(CLK), .rst(rst), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

endmodule

`default_nettype wire

/* cache_assertions.sv */
// concurrent handshake checks, bound into every l1_cache instance by the testbench
`timescale 1ns/100ps
`default_nettype none

module cache_assertions (
    input logic                CLK,
    input logic                rst,
    input cache_pkg::gen_req_t proc_req,
    input cache_pkg::gen_rsp_t proc_rsp,
    input cache_pkg::gen_req_t mem_req,
    input cache_pkg::gen_rsp_t mem_rsp,
    input logic                flush_done,
    input logic                clear_done
);
    int fail_count;   // assertion failures so far

    // a memory word stays put until its completion cycle
    mem_held: assert property (@(posedge CLK) disable iff (rst)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request changed before completion");
        end

    flush_pulse: assert property (@(posedge CLK) disable iff (rst)
        flush_done |=> !flush_done)
        else begin
            fail_count++;
            $error("flush_done longer than one cycle");
        end

    clear_pulse: assert property (@(posedge CLK) disable iff (rst)
        clear_done |=> !clear_done)
        else begin
            fail_count++;
            $error("clear_done longer than one cycle");
        end

    // completion only for a request that is still on the port
    busy_needs_req: assert property (@(posedge CLK) disable iff (rst)
        !proc_rsp.busy |-> (proc_req.ren || proc_req.wen))
        else begin
            fail_count++;
            $error("busy dropped with no processor request");
        end

endmodule

`default_nettype wire

/* cache_tb.sv */
// testbench for cache_subsystem: seeded random traffic on both CPU ports, checked against a word model
`timescale 1ns/100ps
`default_nettype none

module cache_tb;
    localparam int          MEM_WORDS  = 1024;
    localparam int          WAIT_LIMIT = 2000;            // cycles per wait loop
    localparam logic [31:0] NC_START   = 32'h8000_0000;
    localparam logic [31:0] NC_BASE    = 32'h8000_0800;   // shared uncached words, 512 up

    logic                CLK = 1'b0;
    logic                rst;
    logic [1:0]          clear;
    logic [1:0]          flush;
    logic [1:0]          clear_done;
    logic [1:0]          flush_done;
    cache_pkg::gen_req_t proc_req [2];
    cache_pkg::gen_rsp_t proc_rsp [2];

    logic [31:0] model [MEM_WORDS];   // flat reference memory, zero after reset like the DUT
    int          err_count;
    int          check_count;
    bit          stalled;             // a wait ran out, remaining traffic is skipped

    always #2 CLK = ~CLK;   // 4 ns period

    cache_subsystem #(
        .CACHE_SIZE(256), .BLOCK_SIZE(2), .NONCACHE_START_ADDR(NC_START),
        .NUM_CPUS(2), .MEM_LATENCY(3), .MEM_WORDS(MEM_WORDS)
    ) uut (
        .CLK(CLK), .rst(rst), .clear(clear), .flush(flush),
        .clear_done(clear_done), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp)
    );

    bind l1_cache cache_assertions handshake_chk (
        .CLK(CLK), .rst(rst), .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp), .flush_done(flush_done), .clear_done(clear_done)
    );

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % MEM_WORDS);   // memory wraps on word address
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                model[word_index(addr)][8*b +: 8] = data[8*b +: 8];   // enabled lanes only
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t %s: expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // one word on a processor port, caller sits on a rising edge
    task automatic access(input int c, input bit wr, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be,
                          output logic [31:0] rdata);
        cache_pkg::gen_req_t req;
        int                  waited;
        rdata  = '0;
        waited = 0;
        if (stalled) return;
        req         = '0;
        req.ren     = !wr;
        req.wen     = wr;
        req.addr    = addr;
        req.wdata   = wdata;
        req.byte_en = be;
        proc_req[c] <= req;   // held until busy drops
        do begin
            @(posedge CLK);
            waited++;
        end while (proc_rsp[c].busy && waited < WAIT_LIMIT);
        proc_req[c] <= '0;    // released at the completion edge
        if (proc_rsp[c].busy) begin
            $display("cpu%0d %s at %h never finished", c, wr ? "write" : "read", addr);
            err_count++;
            stalled = 1'b1;
        end else begin
            rdata = proc_rsp[c].rdata;
        end
    endtask

    task automatic write_word(input int c, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        logic [31:0] unused;
        access(c, 1'b1, addr, data, be, unused);
        if (!stalled)
            model_write(addr, data, be);   // visible once completed
    endtask

    task automatic read_check(input int c, input logic [31:0] addr);
        logic [31:0] got;
        access(c, 1'b0, addr, '0, '0, got);
        if (!stalled)
            check_value($sformatf("cpu%0d read %h", c, addr), model[word_index(addr)], got);
    endtask

    // flush or clear pulse, then wait for its done pulse
    task automatic maintain(input int c, input bit do_flush);
        int waited;
        waited = 0;
        if (stalled) return;
        if (do_flush)
            flush[c] <= 1'b1;
        else
            clear[c] <= 1'b1;
        do begin
            @(posedge CLK);
            flush[c] <= 1'b0;   // one cycle only
            clear[c] <= 1'b0;
            waited++;
        end while (!(do_flush ? flush_done[c] : clear_done[c]) && waited < WAIT_LIMIT);
        if (!(do_flush ? flush_done[c] : clear_done[c])) begin
            $display("cpu%0d %s never finished", c, do_flush ? "flush" : "clear");
            err_count++;
            stalled = 1'b1;
        end
    endtask

    task automatic random_traffic(input int c, input int n);
        logic [31:0] addr;
        for (int i = 0; i < n; i++) begin
            addr = 32'(c) * 32'h400 + 32'($urandom_range(0, 255)) * 4;   // private 1 KB
            if ($urandom_range(0, 1))
                write_word(c, addr, $urandom, 4'($urandom_range(1, 15)));
            else
                read_check(c, addr);
        end
    endtask

    task automatic set_conflicts(input int c);
        logic [31:0] base;
        base = 32'(c) * 32'h400 + 32'($urandom_range(0, 31)) * 8;   // one set, four tags
        for (int k = 0; k < 4; k++)
            for (int w = 0; w < 2; w++)
                write_word(c, base + k * 256 + w * 4, $urandom, 4'($urandom_range(1, 15)));
        for (int k = 0; k < 4; k++)
            for (int w = 0; w < 2; w++)
                read_check(c, base + k * 256 + w * 4);
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s finished, %0d mismatches", name, err_count - mark);
    endtask

    initial begin
        logic [31:0] addr_list [8];
        logic [31:0] shared;
        int          mark;
        void'($urandom(4481));
        err_count   = 0;
        check_count = 0;
        stalled     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            model[i] = '0;
        rst         <= 1'b1;
        clear       <= '0;
        flush       <= '0;
        proc_req[0] <= '0;
        proc_req[1] <= '0;
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        @(posedge CLK);

        mark = err_count;
        for (int c = 0; c < 2; c++) begin
            check_value($sformatf("cpu%0d busy after reset", c), 32'd1, 32'(proc_rsp[c].busy));
            check_value($sformatf("cpu%0d flush_done after reset", c), 32'd0, 32'(flush_done[c]));
            check_value($sformatf("cpu%0d clear_done after reset", c), 32'd0, 32'(clear_done[c]));
        end
        write_word(0, 32'h0000_0010, 32'ha5c3_1e7b, 4'b1011);
        read_check(0, 32'h0000_0010);
        report_test("reset state and write-read", mark);

        mark = err_count;
        fork
            random_traffic(0, 150);
            random_traffic(1, 150);
        join
        report_test("random private traffic", mark);

        mark = err_count;
        fork
            repeat (4) set_conflicts(0);
            repeat (4) set_conflicts(1);
        join
        report_test("set conflicts and writebacks", mark);

        mark = err_count;
        for (int i = 0; i < 8; i++) begin
            shared = NC_BASE + 32'($urandom_range(0, 15)) * 4;
            write_word(i % 2, shared, $urandom, 4'($urandom_range(1, 15)));
            read_check(1 - i % 2, shared);   // other cpu sees it at once
        end
        report_test("shared uncached region", mark);

        mark = err_count;
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = 32'($urandom_range(0, 255)) * 4;   // cpu0 region
            write_word(0, addr_list[i], $urandom, 4'hf);
        end
        maintain(0, 1'b1);
        for (int i = 0; i < 8; i++)
            read_check(1, addr_list[i]);
        report_test("flush then remote read", mark);

        mark = err_count;
        shared = 32'($urandom_range(0, 255)) * 4;
        read_check(1, shared);   // line now held by cpu1
        write_word(0, shared, ~model[word_index(shared)], 4'hf);
        maintain(0, 1'b1);
        maintain(1, 1'b0);
        read_check(1, shared);
        report_test("clear drops stale line", mark);

        err_count = err_count + uut.g_cpu[0].dcache.cache.handshake_chk.fail_count
                              + uut.g_cpu[1].dcache.cache.handshake_chk.fail_count;
        $display("checks %0d, failures %0d", check_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
cache_pkg.sv
l1_cache.sv
l1_cache_noncoherent.sv
bus_ctrl.sv
main_memory.sv
cache_subsystem.sv
cache_assertions.sv
cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - cache_pkg.sv
  - l1_cache.sv
  - l1_cache_noncoherent.sv
  - bus_ctrl.sv
  - main_memory.sv
  - cache_subsystem.sv
  - target: simulation
    files:
      - cache_assertions.sv
      - cache_tb.sv
